/* pair_alu_pkg.sv */
`default_nettype none

package pair_alu_pkg;

    // operand and result widths, unsigned arithmetic only
    localparam int OPERAND_W = 16;
    localparam int SUM_W     = OPERAND_W + 1;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // b is split into two bytes for the two-stage multiply
    localparam int BYTE_W    = OPERAND_W / 2;
    localparam int PART_W    = OPERAND_W + BYTE_W;

    // one input beat
    typedef struct packed {
        logic [OPERAND_W-1:0] a;
        logic [OPERAND_W-1:0] b;
    } operand_pair_t;

    // partial products between the two multiplier stages
    // a times the high byte of b keeps all 24 bits, it is shifted by one byte later
    typedef struct packed {
        logic [PART_W-1:0] lo_part;
        logic [PART_W-1:0] hi_part;
    } partial_t;

    // merged output beat
    typedef struct packed {
        logic [SUM_W-1:0]     sum;
        logic [PRODUCT_W-1:0] product;
    } result_t;

endpackage

`default_nettype wire

/* stream_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface stream_if #(
    parameter type T = logic
) ();

    // handshake, a beat moves on an edge with valid and ready both high
    logic valid;
    logic ready;

    // payload plus end of frame marker
    T     data;
    logic last;

    // producer side
    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    // consumer side
    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

/* pipe_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_regs #(
    parameter type  T           = logic,
    parameter logic VALID_RESET = 1'b0
) (
    input  logic clk,
    input  logic rst_n,

    // upstream handshake
    input  logic i_valid,
    output logic i_ready,
    input  T     i_data,

    // downstream handshake
    output logic o_valid,
    input  logic o_ready,
    output T     o_data
);

    // output register only, or output plus skid buffer
    // the buffer is never occupied on its own
    typedef enum logic [1:0] {
        EMPTY,
        BUSY,
        FULL
    } state_t;

    state_t state;
    state_t state_next;

    logic insert;
    logic remove;
    logic load;
    logic flow;
    logic fill;
    logic flush;
    logic unload;

    logic out_wren;
    logic buf_wren;
    logic use_buf;
    T     buf_data;
    T     sel_data;

    assign insert = i_valid && i_ready;
    assign remove = o_valid && o_ready;

    // empty pipe takes a beat into the output register
    assign load   = (state == EMPTY) && insert && !remove;
    // old beat leaves while a new one replaces it
    assign flow   = (state == BUSY) && insert && remove;
    // downstream stalled, new beat parks in the buffer
    assign fill   = (state == BUSY) && insert && !remove;
    // buffered beat moves up as the output one leaves
    assign flush  = (state == FULL) && !insert && remove;
    // last beat leaves
    assign unload = (state == BUSY) && !insert && remove;

    always_comb begin
        state_next = state;
        if (load || flow || flush) begin
            state_next = BUSY;
        end else if (fill) begin
            state_next = FULL;
        end else if (unload) begin
            state_next = EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= EMPTY;
            i_ready <= 1'b1;
            o_valid <= VALID_RESET;
        end else begin
            state   <= state_next;
            // registered ready, low only with both entries taken
            i_ready <= (state_next != FULL);
            o_valid <= (state_next != EMPTY);
        end
    end

    // data path write enables
    assign out_wren = load || flow || flush;
    assign buf_wren = fill;
    assign use_buf  = flush;
    assign sel_data = use_buf ? buf_data : i_data;

    always_ff @(posedge clk) begin
        if (buf_wren) begin
            buf_data <= i_data;
        end
        if (out_wren) begin
            o_data <= sel_data;
        end
    end

endmodule

`default_nettype wire

/* beat_fork.sv */
`timescale 1ns/1ns
`default_nettype none

module beat_fork (
    input  logic     clk,
    input  logic     rst_n,
    stream_if.sink   in,
    stream_if.source o_sum_br,
    stream_if.source o_prod_br
);

    // set once a branch has the current input beat
    logic sum_taken;
    logic prod_taken;

    logic sum_xfer;
    logic prod_xfer;
    logic in_xfer;

    // same beat broadcast to both branches
    assign o_sum_br.data  = in.data;
    assign o_sum_br.last  = in.last;
    assign o_prod_br.data = in.data;
    assign o_prod_br.last = in.last;

    // a branch that already took the beat is not offered it again
    assign o_sum_br.valid  = in.valid && !sum_taken;
    assign o_prod_br.valid = in.valid && !prod_taken;

    assign sum_xfer  = o_sum_br.valid && o_sum_br.ready;
    assign prod_xfer = o_prod_br.valid && o_prod_br.ready;

    // input completes once every branch still owed the beat accepts it
    assign in.ready = (sum_taken || o_sum_br.ready) && (prod_taken || o_prod_br.ready);
    assign in_xfer  = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_taken  <= 1'b0;
            prod_taken <= 1'b0;
        end else if (in_xfer) begin
            // beat done, next beat goes to both again
            sum_taken  <= 1'b0;
            prod_taken <= 1'b0;
        end else begin
            if (sum_xfer) begin
                sum_taken <= 1'b1;
            end
            if (prod_xfer) begin
                prod_taken <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* sum_path.sv */
`timescale 1ns/1ns
`default_nettype none

module sum_path
    import pair_alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    stream_if.sink   in,
    stream_if.source out
);

    // sum plus frame marker as one skid payload
    typedef struct packed {
        logic             last;
        logic [SUM_W-1:0] sum;
    } sum_beat_t;

    sum_beat_t add_beat;
    sum_beat_t mid_beat;
    sum_beat_t out_beat;
    logic      mid_valid;
    logic      mid_ready;

    // widen both operands so the carry lands in the top bit
    always_comb begin
        add_beat.last = in.last;
        add_beat.sum  = SUM_W'(in.data.a) + SUM_W'(in.data.b);
    end

    pipe_regs #(
        .T (sum_beat_t)
    ) u_add_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (in.valid),
        .i_ready (in.ready),
        .i_data  (add_beat),
        .o_valid (mid_valid),
        .o_ready (mid_ready),
        .o_data  (mid_beat)
    );

    // second stage matches the two-stage product path
    // so the join sees both results of a beat in the same cycle
    pipe_regs #(
        .T (sum_beat_t)
    ) u_align_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (mid_valid),
        .i_ready (mid_ready),
        .i_data  (mid_beat),
        .o_valid (out.valid),
        .o_ready (out.ready),
        .o_data  (out_beat)
    );

    assign out.data = out_beat.sum;
    assign out.last = out_beat.last;

endmodule

`default_nettype wire

/* product_path.sv */
`timescale 1ns/1ns
`default_nettype none

module product_path
    import pair_alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    stream_if.sink   in,
    stream_if.source out
);

    // stage one payload, partial products
    typedef struct packed {
        logic     last;
        partial_t part;
    } part_beat_t;

    // stage two payload, full product
    typedef struct packed {
        logic                 last;
        logic [PRODUCT_W-1:0] product;
    } prod_beat_t;

    part_beat_t part_in;
    part_beat_t part_out;
    prod_beat_t prod_in;
    prod_beat_t prod_out;
    logic       mid_valid;
    logic       mid_ready;

    // a times each byte of b, two 16x8 multipliers
    always_comb begin
        part_in.last         = in.last;
        part_in.part.lo_part = PART_W'(in.data.a) * PART_W'(in.data.b[BYTE_W-1:0]);
        part_in.part.hi_part = PART_W'(in.data.a) * PART_W'(in.data.b[OPERAND_W-1:BYTE_W]);
    end

    pipe_regs #(
        .T (part_beat_t)
    ) u_mul_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (in.valid),
        .i_ready (in.ready),
        .i_data  (part_in),
        .o_valid (mid_valid),
        .o_ready (mid_ready),
        .o_data  (part_out)
    );

    // high partial is worth one byte more, shift then add
    // a*ffff is the largest case and still fits 32 bits
    always_comb begin
        prod_in.last    = part_out.last;
        prod_in.product = PRODUCT_W'(part_out.part.lo_part)
                        + (PRODUCT_W'(part_out.part.hi_part) << BYTE_W);
    end

    pipe_regs #(
        .T (prod_beat_t)
    ) u_add_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (mid_valid),
        .i_ready (mid_ready),
        .i_data  (prod_in),
        .o_valid (out.valid),
        .o_ready (out.ready),
        .o_data  (prod_out)
    );

    assign out.data = prod_out.product;
    assign out.last = prod_out.last;

endmodule

`default_nettype wire

/* result_join.sv */
`timescale 1ns/1ns
`default_nettype none

module result_join
    import pair_alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    stream_if.sink   i_sum,
    stream_if.sink   i_prod,
    stream_if.source out
);

    // merged result plus frame marker
    typedef struct packed {
        logic    last;
        result_t res;
    } join_beat_t;

    join_beat_t join_beat;
    join_beat_t out_beat;
    logic       both_valid;
    logic       join_ready;
    logic       take;

    // a merged beat exists only with both halves present
    assign both_valid = i_sum.valid && i_prod.valid;

    // both branches are pulled on the same edge, never one alone
    assign take         = both_valid && join_ready;
    assign i_sum.ready  = take;
    assign i_prod.ready = take;

    // last comes from the sum side, both sides carry the same flag
    always_comb begin
        join_beat.last        = i_sum.last;
        join_beat.res.sum     = i_sum.data;
        join_beat.res.product = i_prod.data;
    end

    pipe_regs #(
        .T (join_beat_t)
    ) u_out_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (both_valid),
        .i_ready (join_ready),
        .i_data  (join_beat),
        .o_valid (out.valid),
        .o_ready (out.ready),
        .o_data  (out_beat)
    );

    assign out.data = out_beat.res;
    assign out.last = out_beat.last;

endmodule

`default_nettype wire

/* pair_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module pair_alu
    import pair_alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    // operand pair input stream
    input  logic                 i_valid,
    output logic                 i_ready,
    input  logic [OPERAND_W-1:0] i_a,
    input  logic [OPERAND_W-1:0] i_b,
    input  logic                 i_last,

    // result output stream
    output logic                 o_valid,
    input  logic                 o_ready,
    output logic [SUM_W-1:0]     o_sum,
    output logic [PRODUCT_W-1:0] o_product,
    output logic                 o_last
);

    stream_if #(.T(operand_pair_t))         in_s ();
    stream_if #(.T(operand_pair_t))         fork_sum_s ();
    stream_if #(.T(operand_pair_t))         fork_prod_s ();
    stream_if #(.T(logic [SUM_W-1:0]))      sum_s ();
    stream_if #(.T(logic [PRODUCT_W-1:0]))  prod_s ();
    stream_if #(.T(result_t))               out_s ();

    // top ports onto the input stream
    assign in_s.valid = i_valid;
    assign in_s.data  = '{a: i_a, b: i_b};
    assign in_s.last  = i_last;
    assign i_ready    = in_s.ready;

    beat_fork u_fork (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (in_s),
        .o_sum_br  (fork_sum_s),
        .o_prod_br (fork_prod_s)
    );

    sum_path u_sum (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (fork_sum_s),
        .out   (sum_s)
    );

    product_path u_prod (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (fork_prod_s),
        .out   (prod_s)
    );

    result_join u_join (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_sum  (sum_s),
        .i_prod (prod_s),
        .out    (out_s)
    );

    // output stream onto top ports
    assign o_valid     = out_s.valid;
    assign out_s.ready = o_ready;
    assign o_sum       = out_s.data.sum;
    assign o_product   = out_s.data.product;
    assign o_last      = out_s.last;

endmodule

`default_nettype wire

/* pair_alu_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module pair_alu_checker
    import pair_alu_pkg::*;
(
    input logic                 clk,
    input logic                 rst_n,
    input logic                 i_in_valid,
    input logic                 i_in_ready,
    input logic                 i_out_valid,
    input logic                 i_out_ready,
    input logic [SUM_W-1:0]     i_out_sum,
    input logic [PRODUCT_W-1:0] i_out_product,
    input logic                 i_out_last,
    input logic                 i_sum_valid,
    input logic                 i_sum_ready,
    input logic                 i_sum_last,
    input logic                 i_prod_last
);

    // a stalled input beat stays offered
    in_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        i_in_valid && !i_in_ready |=> i_in_valid)
        else $error("input valid dropped before its transfer");

    // stalled output beat keeps valid and payload
    out_beat_held: assert property (@(posedge clk) disable iff (!rst_n)
        i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_sum)
            && $stable(i_out_product) && $stable(i_out_last))
        else $error("output beat changed while stalled");

    // both branches carry the same frame marker
    join_last_agree: assert property (@(posedge clk) disable iff (!rst_n)
        i_sum_valid && i_sum_ready |-> i_sum_last == i_prod_last)
        else $error("branch last flags differ at the join");

endmodule

bind pair_alu pair_alu_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_in_valid    (i_valid),
    .i_in_ready    (i_ready),
    .i_out_valid   (o_valid),
    .i_out_ready   (o_ready),
    .i_out_sum     (o_sum),
    .i_out_product (o_product),
    .i_out_last    (o_last),
    .i_sum_valid   (sum_s.valid),
    .i_sum_ready   (sum_s.ready),
    .i_sum_last    (sum_s.last),
    .i_prod_last   (prod_s.last)
);

`default_nettype wire

/* tb_pair_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pair_alu
    import pair_alu_pkg::*;
();

    // beat counts per test
    localparam int CORNER_BEATS = 4;
    localparam int STREAM_BEATS = 64;
    localparam int STALL_BEATS  = 24;
    localparam int RAND_BEATS   = 200;
    localparam int STALL_CYCLES = 20;
    localparam int TOTAL_BEATS  = CORNER_BEATS + STREAM_BEATS + STALL_BEATS + RAND_BEATS;
    // timeout limit grows with the total beat count
    localparam int MAX_CYCLES   = TOTAL_BEATS * 4 + 200;
    // a full pipe empties well within this many cycles
    localparam int DRAIN_CYCLES = 64;

    // expected output beat
    typedef struct packed {
        result_t res;
        logic    last;
    } expect_t;

    logic                 clk       = 1'b0;
    logic                 rst_n     = 1'b0;
    logic                 i_valid   = 1'b0;
    logic [OPERAND_W-1:0] i_a       = '0;
    logic [OPERAND_W-1:0] i_b       = '0;
    logic                 i_last    = 1'b0;
    logic                 o_ready   = 1'b1;
    logic                 i_ready;
    logic                 o_valid;
    logic [SUM_W-1:0]     o_sum;
    logic [PRODUCT_W-1:0] o_product;
    logic                 o_last;

    // 0 holds o_ready high, 1 holds it low, 2 toggles it randomly
    logic [1:0]           ready_mode  = 2'd0;
    int                   cycle_count = 0;
    int                   out_count   = 0;
    expect_t              expected_q[$];

    pair_alu dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_valid   (i_valid),
        .i_ready   (i_ready),
        .i_a       (i_a),
        .i_b       (i_b),
        .i_last    (i_last),
        .o_valid   (o_valid),
        .o_ready   (o_ready),
        .o_sum     (o_sum),
        .o_product (o_product),
        .o_last    (o_last)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                                name, expected, actual));
        end
    endtask

    // sole driver of o_ready
    always @(posedge clk) begin
        case (ready_mode)
            2'd1: o_ready <= 1'b0;
            2'd2: o_ready <= ($urandom % 3) != 0;
            default: o_ready <= 1'b1;
        endcase
    end

    // reference model on input transfers, scoreboard on output transfers
    always @(posedge clk) begin
        expect_t exp_beat;
        if (rst_n) begin
            if (i_valid && i_ready) begin
                exp_beat.res.sum     = {1'b0, i_a} + {1'b0, i_b};
                exp_beat.res.product = {16'h0000, i_a} * {16'h0000, i_b};
                exp_beat.last        = i_last;
                expected_q.push_back(exp_beat);
            end
            if (o_valid && o_ready) begin
                if (expected_q.size() == 0) begin
                    abort_run("output beat appeared with no matching input beat");
                end else begin
                    exp_beat = expected_q.pop_front();
                    check_value("o_sum", 64'(exp_beat.res.sum), 64'(o_sum));
                    check_value("o_product", 64'(exp_beat.res.product), 64'(o_product));
                    check_value("o_last", 64'(exp_beat.last), 64'(o_last));
                    out_count <= out_count + 1;
                end
            end
        end
    end

    // hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles, the DUT stopped moving beats",
                                cycle_count));
        end
    end

    // offer one beat and hold it until the edge that transfers it
    task automatic send_beat(input logic [OPERAND_W-1:0] a, input logic [OPERAND_W-1:0] b,
                             input logic last);
        i_valid <= 1'b1;
        i_a     <= a;
        i_b     <= b;
        i_last  <= last;
        do @(posedge clk); while (!i_ready);
    endtask

    task automatic go_idle();
        i_valid <= 1'b0;
        @(posedge clk);
    endtask

    // returns once the scoreboard is empty or the drain limit passes
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
    endtask

    task automatic idle_after_reset();
        check_value("o_valid", 64'(1'b0), 64'(o_valid));
        check_value("i_ready", 64'(1'b1), 64'(i_ready));
    endtask

    task automatic corner_operands();
        send_beat(16'h0000, 16'h0000, 1'b1);
        go_idle();
        wait_drain();
        send_beat(16'hffff, 16'hffff, 1'b0);
        go_idle();
        wait_drain();
        send_beat(16'hffff, 16'h0001, 1'b1);
        go_idle();
        wait_drain();
        send_beat(16'h0001, 16'hffff, 1'b0);
        go_idle();
        wait_drain();
    endtask

    task automatic back_to_back_stream();
        int start_count;
        start_count = out_count;
        for (int n = 0; n < STREAM_BEATS; n++) begin
            send_beat(16'($urandom), 16'($urandom), n == STREAM_BEATS - 1);
        end
        go_idle();
        wait_drain();
        @(posedge clk);
        check_value("output beat count", 64'(STREAM_BEATS), 64'(out_count - start_count));
    endtask

    task automatic output_stall();
        logic low_seen;
        low_seen = 1'b0;
        ready_mode <= 2'd1;
        fork
            begin
                for (int n = 0; n < STALL_BEATS; n++) begin
                    send_beat(16'($urandom), 16'($urandom), n == STALL_BEATS - 1);
                end
                go_idle();
            end
            begin
                repeat (STALL_CYCLES) begin
                    @(posedge clk);
                    if (!i_ready) begin
                        low_seen = 1'b1;
                    end
                end
                ready_mode <= 2'd0;
            end
        join
        check_value("i_ready low during stall", 64'(1'b1), 64'(low_seen));
        wait_drain();
    endtask

    task automatic random_stalls();
        ready_mode <= 2'd2;
        for (int n = 0; n < RAND_BEATS; n++) begin
            // random gaps on the input side
            while (($urandom % 4) == 0) go_idle();
            send_beat(16'($urandom), 16'($urandom), 1'($urandom));
        end
        go_idle();
        ready_mode <= 2'd0;
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'h422b_e108));
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        idle_after_reset();
        corner_operands();
        back_to_back_stream();
        output_stall();
        random_stalls();
        wait_drain();
        repeat (4) @(posedge clk);
        if (expected_q.size() != 0) begin
            abort_run($sformatf("%0d accepted beats never came out", expected_q.size()));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* pair_alu.f */
pair_alu_pkg.sv
stream_if.sv
pipe_regs.sv
beat_fork.sv
sum_path.sv
product_path.sv
result_join.sv
pair_alu.sv
pair_alu_checker.sv
tb_pair_alu.sv

/* run.sh */
#!/bin/sh
# build and run the pair_alu testbench, exit status reports pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
    -f pair_alu.f \
    --top-module tb_pair_alu \
    -o sim_pair_alu \
    && ./obj_dir/sim_pair_alu \
    || { echo "pair_alu simulation did not pass"; exit 1; }
